//--- sim.f
hdl/pll_pkg.sv
hdl/la_pll.sv
hdl/pll_seq_timer.sv
hdl/pll_seq_fsm.sv
hdl/pll_cfg_regs.sv
hdl/pll_freq_meter.sv
hdl/pll_subsys_top.sv
test/pll_subsys_sva.sv
test/pll_subsys_tb.sv

//--- Makefile
# Verilator build and run for the PLL subsystem testbench

VERILATOR ?= verilator
TOP       ?= pll_subsys_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/pll_subsys_tb.sv
//####################################################################
// testbench for the PLL subsystem: a table of start, stop, load and
// measure rows is built from a small model, then applied in a loop
//####################################################################
`default_nettype none

module pll_subsys_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import pll_pkg::*;

   localparam int    NOUT        = 2;
   localparam tick_t RST_CYCLES  = 6;
   localparam tick_t LOCK_CYCLES = 8;
   localparam meas_t WINDOW      = 64;
   localparam int    BRINGUP     = int'(RST_CYCLES) + int'(LOCK_CYCLES) + 3;  // strobe to ready
   localparam int    ROW_CYCLES  = 40;   // budget per row
   localparam int    MAX_ROWS    = 16;

   typedef enum logic [1:0] {op_start, op_stop, op_load, op_measure} op_t;

   typedef struct packed {
      op_t                op;
      logic               bypass;
      divin_t             divin;
      divfb_t             divfb;
      divout_t [NOUT-1:0] divout;
      phase_t  [NOUT-1:0] phase;
      logic    [NOUT-1:0] clken;
      logic               relock;      // load while running
      logic               exp_ready;
      divin_t             exp_divin;
      divfb_t             exp_divfb;
      logic    [NOUT-1:0] exp_clken;
      meas_t   [NOUT-1:0] exp_meas;
   } row_t;

   logic clk, reset, start, stop, cfg_load, bypass, meas_start;
   divin_t             cfg_divin;
   divfb_t             cfg_divfb;
   divout_t [NOUT-1:0] cfg_divout;
   phase_t  [NOUT-1:0] cfg_phase;
   logic    [NOUT-1:0] cfg_clken;
   logic               ready, locked, meas_done;
   logic    [NOUT-1:0] clkout;
   divin_t             act_divin;
   divfb_t             act_divfb;
   logic    [NOUT-1:0] act_clken;
   meas_t   [NOUT-1:0] meas_count;

   row_t        table_q [MAX_ROWS];
   int          n_rows;
   logic [31:0] rng_state;
   int          errors, checks, loads_seen;
   int          cycle_count = 0;
   int          cycle_limit;
   // reference model of the readback, built along with the table
   logic            model_ready;
   divin_t          shadow_divin, model_divin;
   divfb_t          shadow_divfb, model_divfb;
   logic [NOUT-1:0] shadow_clken, model_clken;

   pll_subsys_top #(
      .NOUT(NOUT), .RST_CYCLES(RST_CYCLES), .LOCK_CYCLES(LOCK_CYCLES), .WINDOW(WINDOW)
   ) dut (
      .clkin(clk), .reset, .start, .stop, .cfg_load, .bypass, .meas_start,
      .cfg_divin, .cfg_divfb, .cfg_divout, .cfg_phase, .cfg_clken,
      .ready, .locked, .meas_done, .clkout,
      .act_divin, .act_divfb, .act_clken, .meas_count
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // run limit, 40 per row plus a window per measurement
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: no end of test after %0d cycles", cycle_count);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   //####################################################################
   // helpers
   //####################################################################
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic string op_text(input op_t op);
      case (op)
         op_start: return "start";
         op_stop:  return "stop";
         op_load:  return "load";
         default:  return "measure";
      endcase
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic add_row(input op_t op, input logic byp);
      row_t r;
      int   i;
      r        = '0;
      r.op     = op;
      r.bypass = byp;
      rng_state = xorshift32(rng_state);
      r.divin   = rng_state[7:0];
      r.divfb   = rng_state[15:8];
      r.clken   = rng_state[16 +: NOUT];
      for (i = 0; i < NOUT; i++) begin
         rng_state   = xorshift32(rng_state);
         r.divout[i] = rng_state[7:0];
         r.phase[i]  = rng_state[15:8];
      end
      if (op == op_load && loads_seen == 0)
         for (i = 0; i < NOUT; i++)
            r.clken[i] = (i % 2 == 1);   // first load mixes open and closed outputs
      case (op)
         op_load: begin
            loads_seen++;
            shadow_divin = r.divin;
            shadow_divfb = r.divfb;
            shadow_clken = r.clken;
            r.relock     = model_ready;
            if (model_ready) begin       // relock copies the new words
               model_divin = shadow_divin;
               model_divfb = shadow_divfb;
               model_clken = shadow_clken;
            end
         end
         op_start: begin
            model_divin = shadow_divin;
            model_divfb = shadow_divfb;
            model_clken = shadow_clken;
            model_ready = 1'b1;
         end
         op_stop: model_ready = 1'b0;
         default: begin
            for (i = 0; i < NOUT; i++)
               r.exp_meas[i] = (byp || (model_ready && model_clken[i])) ? WINDOW : '0;
            cycle_limit += int'(WINDOW);
         end
      endcase
      r.exp_ready = model_ready;
      r.exp_divin = model_divin;
      r.exp_divfb = model_divfb;
      r.exp_clken = model_clken;
      table_q[n_rows] = r;
      n_rows++;
      cycle_limit += ROW_CYCLES;
   endtask

   task automatic clear_strobes();
      start      <= 1'b0;
      stop       <= 1'b0;
      cfg_load   <= 1'b0;
      meas_start <= 1'b0;
   endtask

   // counts edges until ready is seen high, sampled mid cycle
   task automatic wait_ready(output int n);
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < ROW_CYCLES) begin
         @(posedge clk);
         clear_strobes();
         n++;
         @(negedge clk);
         seen = ready;
      end
   endtask

   //####################################################################
   // one table row
   //####################################################################
   task automatic apply_row(input row_t r, input row_t prev);
      int              n;
      int              i;
      logic            done;
      logic [NOUT-1:0] exp_clkout;
      @(posedge clk);
      bypass <= r.bypass;
      case (r.op)
         op_start: begin
            start <= 1'b1;
            wait_ready(n);
            check_value("cycles start to ready", 32'(n), 32'(BRINGUP));
         end
         op_stop: begin
            stop <= 1'b1;
            @(posedge clk);
            clear_strobes();
            @(negedge clk);
            check_value("ready after stop", 32'(ready), 32'd0);
         end
         op_load: begin
            cfg_divin  <= r.divin;
            cfg_divfb  <= r.divfb;
            cfg_divout <= r.divout;
            cfg_phase  <= r.phase;
            cfg_clken  <= r.clken;
            cfg_load   <= 1'b1;
            @(posedge clk);
            clear_strobes();
            @(negedge clk);
            if (r.relock) begin
               check_value("ready drop on relock", 32'(ready), 32'd0);
               check_value("act_divin before apply", 32'(act_divin), 32'(prev.exp_divin));
               check_value("act_divfb before apply", 32'(act_divfb), 32'(prev.exp_divfb));
               wait_ready(n);
               check_value("cycles load to ready", 32'(n + 1), 32'(BRINGUP));
            end else begin
               repeat (2) @(negedge clk);   // shadow only
            end
         end
         default: begin
            meas_start <= 1'b1;
            n    = 0;
            done = 1'b0;
            while (!done && n < int'(WINDOW) + ROW_CYCLES) begin
               @(posedge clk);
               clear_strobes();
               n++;
               @(negedge clk);
               done = meas_done;
            end
            check_value("meas_done seen", 32'(done), 32'd1);
            for (i = 0; i < NOUT; i++)
               check_value($sformatf("meas_count[%0d]", i), 32'(meas_count[i]),
                           32'(r.exp_meas[i]));
         end
      endcase
      // steady state after every row
      check_value("ready", 32'(ready), 32'(r.exp_ready));
      check_value("locked", 32'(locked), 32'(r.exp_ready));
      check_value("act_divin", 32'(act_divin), 32'(r.exp_divin));
      check_value("act_divfb", 32'(act_divfb), 32'(r.exp_divfb));
      check_value("act_clken", 32'(act_clken), 32'(r.exp_clken));
      // output clocks seen inside the high phase of the reference
      exp_clkout = r.bypass ? '1 : (r.exp_ready ? r.exp_clken : '0);
      @(posedge clk);
      #2;
      check_value("clkout", 32'(clkout), 32'(exp_clkout));
   endtask

   //####################################################################
   // main sequence
   //####################################################################
   initial begin
      int k;
      int errors_before;
      reset      = 1'b1;
      start      = 1'b0;
      stop       = 1'b0;
      cfg_load   = 1'b0;
      bypass     = 1'b0;
      meas_start = 1'b0;
      cfg_divin  = '0;
      cfg_divfb  = '0;
      cfg_divout = '0;
      cfg_phase  = '0;
      cfg_clken  = '0;
      rng_state  = 32'h1b22_ddba;
      n_rows     = 0;
      errors     = 0;
      checks     = 0;
      loads_seen = 0;
      cycle_limit  = 4;              // reset cycles
      model_ready  = 1'b0;
      shadow_divin = divin_t'(1);    // register defaults
      shadow_divfb = divfb_t'(1);
      shadow_clken = '1;
      model_divin  = shadow_divin;
      model_divfb  = shadow_divfb;
      model_clken  = shadow_clken;

      add_row(op_measure, 1'b0);     // after reset, nothing runs
      add_row(op_load,    1'b0);     // stopped, shadow only
      add_row(op_start,   1'b0);
      add_row(op_measure, 1'b0);
      add_row(op_load,    1'b0);     // relock
      add_row(op_measure, 1'b0);
      add_row(op_stop,    1'b0);
      add_row(op_measure, 1'b0);
      add_row(op_measure, 1'b1);     // bypass while stopped
      add_row(op_load,    1'b0);
      add_row(op_start,   1'b0);
      add_row(op_measure, 1'b0);

      repeat (4) @(posedge clk);
      reset <= 1'b0;
      for (k = 0; k < n_rows; k++) begin
         errors_before = errors;
         apply_row(table_q[k], (k > 0) ? table_q[k-1] : table_q[k]);
         $display("row %0d %s %s", k, op_text(table_q[k].op),
                  (errors == errors_before) ? "ok" : "mismatch");
      end
      $display("rows %0d checks %0d errors %0d", n_rows, checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/pll_subsys_sva.sv
//####################################################################
// assertions on the sequencer outputs, bound into pll_seq_fsm
//####################################################################
`default_nettype none

module pll_subsys_sva (
   input logic clkin,
   input logic reset,
   input logic ready,
   input logic pll_en,
   input logic pll_reset,
   input logic cfg_apply
);
   timeunit 1ns;
   timeprecision 1ps;

   // outputs open only on an enabled pll
   ready_needs_en: assert property (@(posedge clkin) disable iff (reset)
      ready |-> pll_en)
      else $error("ready high while pll_en low");

   reset_en_excl: assert property (@(posedge clkin) disable iff (reset)
      !(pll_reset && pll_en))
      else $error("pll_reset and pll_en high together");

   // active bank changes only while the pll is held
   apply_in_reset: assert property (@(posedge clkin) disable iff (reset)
      cfg_apply |-> pll_reset)
      else $error("cfg_apply outside the reset hold");

endmodule

bind pll_seq_fsm pll_subsys_sva u_sva (
   .clkin     (clkin),
   .reset     (reset),
   .ready     (ready),
   .pll_en    (pll_en),
   .pll_reset (pll_reset),
   .cfg_apply (cfg_apply)
);

`default_nettype wire

//--- hdl/pll_subsys_top.sv
//####################################################################
// PLL subsystem top: sequencer, timer, config registers, PLL wrapper
// and frequency meter, all controlled from the reference clock
//####################################################################
`default_nettype none

module pll_subsys_top #(
   parameter int             NOUT        = 2,
   parameter pll_pkg::tick_t RST_CYCLES  = 6,
   parameter pll_pkg::tick_t LOCK_CYCLES = 8,
   parameter pll_pkg::meas_t WINDOW      = 64
) (
   input  logic                         clkin,       // reference and control clock
   input  logic                         reset,
   input  logic                         start,
   input  logic                         stop,
   input  logic                         cfg_load,
   input  logic                         bypass,
   input  logic                         meas_start,
   input  pll_pkg::divin_t              cfg_divin,
   input  pll_pkg::divfb_t              cfg_divfb,
   input  pll_pkg::divout_t [NOUT-1:0]  cfg_divout,
   input  pll_pkg::phase_t  [NOUT-1:0]  cfg_phase,
   input  logic [NOUT-1:0]              cfg_clken,
   output logic                         ready,
   output logic                         locked,
   output logic                         meas_done,
   output logic [NOUT-1:0]              clkout,
   output pll_pkg::divin_t              act_divin,
   output pll_pkg::divfb_t              act_divfb,
   output logic [NOUT-1:0]              act_clken,
   output pll_pkg::meas_t [NOUT-1:0]    meas_count
);
   import pll_pkg::*;

   logic               tmr_load;
   logic               tmr_zero;
   tick_t              tmr_value;
   logic               cfg_apply;
   logic               cfg_pending;
   logic               pll_reset;
   logic               pll_en;
   logic               clken_gate;
   logic [NOUT-1:0]    pll_clken;
   divout_t [NOUT-1:0] act_divout;
   phase_t  [NOUT-1:0] act_phase;
   wire                supply_hi;   // tie-offs for the supply pins
   wire                supply_lo;

   assign supply_hi = 1'b1;
   assign supply_lo = 1'b0;

   //####################################################################
   // sequencing
   //####################################################################
   pll_seq_fsm #(.RST_CYCLES(RST_CYCLES), .LOCK_CYCLES(LOCK_CYCLES)) u_fsm (
      .clkin, .reset, .start, .stop,
      .freqlock (locked),
      .cfg_pending, .tmr_zero, .tmr_load, .tmr_value, .cfg_apply,
      .pll_reset, .pll_en, .clken_gate, .ready
   );

   pll_seq_timer u_timer (.clkin, .reset, .tmr_load, .tmr_value, .tmr_zero);

   pll_cfg_regs #(.NOUT(NOUT)) u_cfg (
      .clkin, .reset, .cfg_load, .cfg_apply,
      .running (ready),
      .clken_gate, .cfg_divin, .cfg_divfb, .cfg_divout, .cfg_phase, .cfg_clken,
      .act_divin, .act_divfb, .act_divout, .act_phase, .act_clken,
      .pll_clken, .cfg_pending
   );

   //####################################################################
   // pll and meter
   //####################################################################
   la_pll #(
      .NIN     (1),
      .NOUT    (NOUT),
      .DIVINW  ($bits(divin_t)),
      .DIVFBW  ($bits(divfb_t)),
      .DIVOUTW ($bits(divout_t)),
      .PHASEW  ($bits(phase_t))
   ) u_pll (
      .vdda      (supply_hi),
      .vdd       (supply_hi),
      .vddaux    (supply_hi),
      .vss       (supply_lo),
      .clkin     (clkin),
      .clkout    (clkout),
      .clkfbin   (1'b0),        // internal feedback
      .clkfbout  (),
      .clkvco    (),
      .reset     (pll_reset),
      .en        (pll_en),
      .bypass    (bypass),
      .clksel    (1'b0),
      .clken     (pll_clken),
      .divin     (act_divin),
      .divfb     (act_divfb),
      .divfrac   ('0),
      .divout    (act_divout),
      .phase     (act_phase),
      .freqlock  (locked),
      .phaselock (),
      .ctrl      ('0),
      .status    ()
   );

   pll_freq_meter #(.NOUT(NOUT), .WINDOW(WINDOW)) u_meter (
      .clkin, .reset, .meas_start, .clkout, .meas_count, .meas_done
   );

endmodule

`default_nettype wire

//--- hdl/pll_freq_meter.sv
//####################################################################
// frequency meter: counts rising edges of each PLL output over a
// window of WINDOW reference cycles started by meas_start
//####################################################################
`default_nettype none

module pll_freq_meter #(
   parameter int             NOUT   = 2,
   parameter pll_pkg::meas_t WINDOW = 64   // window in clkin cycles
) (
   input  logic                       clkin,
   input  logic                       reset,
   input  logic                       meas_start,  // clears result, opens window
   input  logic [NOUT-1:0]            clkout,      // clocks under test
   output pll_pkg::meas_t [NOUT-1:0]  meas_count,
   output logic                       meas_done    // one cycle with result
);
   import pll_pkg::*;

   meas_t win_cnt;      // cycles left in window
   logic  win_active;   // edge counters enabled
   logic  win_end;      // last counted edge passed

   //####################################################################
   // window control, clkin domain
   //####################################################################
   always_ff @(posedge clkin) begin
      if (reset) begin
         win_cnt    <= '0;
         win_active <= 1'b0;
         win_end    <= 1'b0;
         meas_done  <= 1'b0;
      end else begin
         win_end   <= 1'b0;
         meas_done <= win_end;   // aligned with result capture
         if (meas_start) begin
            win_cnt    <= WINDOW;
            win_active <= 1'b1;
         end else if (win_active) begin
            win_cnt <= win_cnt - 1'b1;
            if (win_cnt == meas_t'(1)) begin
               win_active <= 1'b0;
               win_end    <= 1'b1;
            end
         end
      end
   end

   //####################################################################
   // per output edge counters, result is end minus start snapshot
   //####################################################################
   for (genvar i = 0; i < NOUT; i++) begin : gen_ch
      meas_t edge_cnt;    // runs on clkout[i]
      meas_t start_cnt;   // snapshot at window open
      meas_t result;

      always_ff @(posedge clkout[i]) begin
         if (reset)
            edge_cnt <= '0;
         else if (win_active)
            edge_cnt <= edge_cnt + 1'b1;
      end

      always_ff @(posedge clkin) begin
         if (reset) begin
            start_cnt <= '0;
            result    <= '0;
         end else if (meas_start) begin
            start_cnt <= edge_cnt;
            result    <= '0;
         end else if (win_end) begin
            result <= edge_cnt - start_cnt;   // wraps cleanly
         end
      end

      assign meas_count[i] = result;
   end

endmodule

`default_nettype wire

//--- hdl/pll_cfg_regs.sv
//####################################################################
// PLL configuration: shadow bank written by the user on cfg_load,
// active bank copied from it on cfg_apply during the reset hold
//####################################################################
`default_nettype none

module pll_cfg_regs #(
   parameter int NOUT = 2
) (
   input  logic                         clkin,
   input  logic                         reset,
   input  logic                         cfg_load,     // user write strobe
   input  logic                         cfg_apply,    // from sequencer
   input  logic                         running,      // sequencer ready
   input  logic                         clken_gate,
   input  pll_pkg::divin_t              cfg_divin,
   input  pll_pkg::divfb_t              cfg_divfb,
   input  pll_pkg::divout_t [NOUT-1:0]  cfg_divout,
   input  pll_pkg::phase_t  [NOUT-1:0]  cfg_phase,
   input  logic [NOUT-1:0]              cfg_clken,
   output pll_pkg::divin_t              act_divin,
   output pll_pkg::divfb_t              act_divfb,
   output pll_pkg::divout_t [NOUT-1:0]  act_divout,
   output pll_pkg::phase_t  [NOUT-1:0]  act_phase,
   output logic [NOUT-1:0]              act_clken,
   output logic [NOUT-1:0]              pll_clken,    // gated enables to pll
   output logic                         cfg_pending
);
   import pll_pkg::*;

   divin_t             sh_divin;
   divfb_t             sh_divfb;
   divout_t [NOUT-1:0] sh_divout;
   phase_t  [NOUT-1:0] sh_phase;
   logic    [NOUT-1:0] sh_clken;
   logic               pend_q;     // load seen while running

   //####################################################################
   // shadow and active banks, defaults div 1, phase 0, all enabled
   //####################################################################
   always_ff @(posedge clkin) begin
      if (reset) begin
         sh_divin  <= divin_t'(1);
         sh_divfb  <= divfb_t'(1);
         sh_divout <= {NOUT{divout_t'(1)}};
         sh_phase  <= '0;
         sh_clken  <= '1;
      end else if (cfg_load) begin
         sh_divin  <= cfg_divin;
         sh_divfb  <= cfg_divfb;
         sh_divout <= cfg_divout;
         sh_phase  <= cfg_phase;
         sh_clken  <= cfg_clken;
      end
   end

   always_ff @(posedge clkin) begin
      if (reset) begin
         act_divin  <= divin_t'(1);
         act_divfb  <= divfb_t'(1);
         act_divout <= {NOUT{divout_t'(1)}};
         act_phase  <= '0;
         act_clken  <= '1;
      end else if (cfg_apply) begin
         act_divin  <= sh_divin;
         act_divfb  <= sh_divfb;
         act_divout <= sh_divout;
         act_phase  <= sh_phase;
         act_clken  <= sh_clken;
      end
   end

   always_ff @(posedge clkin) begin
      if (reset)
         pend_q <= 1'b0;
      else if (cfg_load && running)
         pend_q <= 1'b1;
      else if (cfg_apply)
         pend_q <= 1'b0;   // consumed by relock
   end

   // the load strobe itself counts, so relock starts the next cycle
   assign cfg_pending = pend_q | (cfg_load & running);
   assign pll_clken   = act_clken & {NOUT{clken_gate}};

endmodule

`default_nettype wire

//--- hdl/pll_seq_fsm.sv
//####################################################################
// PLL bring-up sequencer: reset hold, lock debounce, run
// start/stop strobes drive it, a pending config load forces a relock
//####################################################################
`default_nettype none

module pll_seq_fsm #(
   parameter pll_pkg::tick_t RST_CYCLES  = 6,   // reset hold length
   parameter pll_pkg::tick_t LOCK_CYCLES = 8    // lock debounce length
) (
   input  logic           clkin,
   input  logic           reset,
   input  logic           start,        // bring-up strobe
   input  logic           stop,         // shutdown strobe
   input  logic           freqlock,
   input  logic           cfg_pending,  // load arrived while running
   input  logic           tmr_zero,
   output logic           tmr_load,
   output pll_pkg::tick_t tmr_value,
   output logic           cfg_apply,    // shadow to active, first reset cycle
   output logic           pll_reset,
   output logic           pll_en,
   output logic           clken_gate,
   output logic           ready
);
   import pll_pkg::*;

   seq_state_t state;
   seq_state_t state_nxt;

   //####################################################################
   // next state, timer loads on entry to a timed phase
   //####################################################################
   always_comb begin
      state_nxt = state;
      tmr_load  = 1'b0;
      tmr_value = RST_CYCLES;
      case (state)
         st_off: begin
            if (start) begin
               state_nxt = st_reset;
               tmr_load  = 1'b1;
            end
         end
         st_reset: begin
            if (tmr_zero) begin           // hold done
               state_nxt = st_lock_wait;
               tmr_load  = 1'b1;
               tmr_value = LOCK_CYCLES;
            end
         end
         st_lock_wait: begin
            tmr_value = LOCK_CYCLES;
            if (!freqlock)
               tmr_load = 1'b1;           // restart debounce
            else if (tmr_zero)
               state_nxt = st_run;
         end
         st_run: begin
            if (cfg_pending) begin        // relock with new settings
               state_nxt = st_reset;
               tmr_load  = 1'b1;
            end else if (!freqlock) begin
               state_nxt = st_lock_wait;
               tmr_load  = 1'b1;
               tmr_value = LOCK_CYCLES;
            end
         end
         default: state_nxt = st_off;
      endcase
      // stop wins from any state
      if (stop) begin
         state_nxt = st_off;
         tmr_load  = 1'b0;
      end
   end

   always_ff @(posedge clkin) begin
      if (reset) begin
         state     <= st_off;
         cfg_apply <= 1'b0;
      end else begin
         state     <= state_nxt;
         cfg_apply <= (state_nxt == st_reset) && (state != st_reset);
      end
   end

   // outputs decoded from state
   assign pll_reset  = (state == st_off) || (state == st_reset);
   assign pll_en     = (state == st_lock_wait) || (state == st_run);
   assign ready      = (state == st_run);
   assign clken_gate = ready;   // outputs open only when locked

endmodule

`default_nettype wire

//--- hdl/pll_seq_timer.sv
//####################################################################
// loadable down-counter for the sequencer, holds at zero
// one instance times both the reset hold and the lock debounce
//####################################################################
`default_nettype none

module pll_seq_timer (
   input  logic           clkin,
   input  logic           reset,
   input  logic           tmr_load,    // load strobe
   input  pll_pkg::tick_t tmr_value,   // count to load
   output logic           tmr_zero     // high while count is zero
);
   import pll_pkg::*;

   tick_t count;

   always_ff @(posedge clkin) begin
      if (reset)
         count <= '0;
      else if (tmr_load)
         count <= tmr_value;
      else if (count != '0)
         count <= count - 1'b1;   // stop at zero
   end

   assign tmr_zero = (count == '0);

endmodule

`default_nettype wire

//--- hdl/la_pll.sv
//####################################################################
// generic PLL wrapper, fast cycle model only
// vco runs at the selected reference clock (N = M = 1), outputs are
// gated per clken, bypass passes the reference straight through
//####################################################################
`default_nettype none

module la_pll #(
   parameter int NIN      = 1,   // reference clock inputs
   parameter int NOUT     = 1,   // output clocks
   parameter int DIVINW   = 8,   // reference divider width
   parameter int DIVFBW   = 8,   // feedback divider width
   parameter int DIVFRACW = 8,   // fractional feedback width
   parameter int DIVOUTW  = 8,   // output divider width
   parameter int PHASEW   = 8,   // phase shift width
   parameter int CW       = 1,   // ctrl width
   parameter int SW       = 1    // status width
) (
   // supplies, pass-through only
   inout  wire                              vdda,
   inout  wire                              vdd,
   inout  wire                              vddaux,
   inout  wire                              vss,
   // clocks
   input  logic [NIN-1:0]                   clkin,     // reference clock(s)
   output logic [NOUT-1:0]                  clkout,    // post divider outputs
   input  logic                             clkfbin,   // external feedback, unused here
   output logic                             clkfbout,
   output logic                             clkvco,
   // controls
   input  logic                             reset,     // holds vco off
   input  logic                             en,
   input  logic                             bypass,
   input  logic [(NIN>1?$clog2(NIN):1)-1:0] clksel,
   input  logic [NOUT-1:0]                  clken,
   input  logic [DIVINW-1:0]                divin,     // N, not modeled
   input  logic [DIVFBW-1:0]                divfb,     // M, not modeled
   input  logic [DIVFRACW-1:0]              divfrac,
   input  logic [NOUT*DIVOUTW-1:0]          divout,    // packed per output
   input  logic [NOUT*PHASEW-1:0]           phase,
   output logic                             freqlock,
   output logic                             phaselock,
   // pll specific
   input  logic [CW-1:0]                    ctrl,
   output logic [SW-1:0]                    status
);

   logic clk;  // selected reference

   //####################################################################
   // reference select and vco
   //####################################################################
   assign clk      = clkin[(NIN == 1) ? 0 : clksel];
   assign clkvco   = clk & en & ~reset;   // N/M = 1
   assign clkfbout = clkvco;

   // per output gate or bypass
   for (genvar i = 0; i < NOUT; i++) begin : gen_out
      assign clkout[i] = bypass ? clk : (clkvco & clken[i]);
   end

   // lock follows enable, no acquisition time
   assign freqlock  = en;
   assign phaselock = en;
   assign status    = '0;   // nothing vendor specific

endmodule

`default_nettype wire

//--- hdl/pll_pkg.sv
//####################################################################
// shared widths and the sequencer state encoding for the PLL
// bring-up subsystem, imported by the modules that need them
//####################################################################
`default_nettype none

package pll_pkg;

   //####################################################################
   // configuration words
   //####################################################################
   typedef logic [7:0] divin_t;    // reference divider N
   typedef logic [7:0] divfb_t;    // feedback divider M
   typedef logic [7:0] divout_t;   // per output divider
   typedef logic [7:0] phase_t;    // per output phase shift

   //####################################################################
   // counters
   //####################################################################
   typedef logic [7:0]  tick_t;    // sequencer timer
   typedef logic [11:0] meas_t;    // meter edge count and window

   // bring-up sequence
   typedef enum logic [1:0] {
      st_off       = 2'd0,  // pll held in reset
      st_reset     = 2'd1,  // reset hold, new config applied here
      st_lock_wait = 2'd2,  // enabled, debouncing freqlock
      st_run       = 2'd3   // locked, outputs open
   } seq_state_t;

endpackage

`default_nettype wire
